//--- source/datapath_consts.svh
// widths, sizes and fixed encodings shared by the datapath RTL and its testbench
`ifndef DATAPATH_CONSTS_SVH
`define DATAPATH_CONSTS_SVH

// data and address width
`define WORD_W 32

// register file geometry
`define REG_CNT 32
`define REG_SEL_W 5

// first fetch address after reset
`define PC_RESET 32'h0000_0000

// all-ones instruction stops the machine
`define HALT_WORD 32'hffff_ffff

// unit-enable bit positions in the issue payload
`define FU_CNT 3
`define FU_ALU 0
`define FU_LSU 1
`define FU_BRU 2

`endif

//--- source/isa_pkg.sv
// instruction encoding and operation types for the reduced RV32I subset
`default_nettype none

`include "datapath_consts.svh"

package isa_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`REG_SEL_W-1:0] reg_sel_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_RTYPE  = 7'b0110011,
        OP_ITYPE  = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_t;

    // R-type field view, other formats reuse rd/rs1/rs2 positions
    typedef struct packed {
        logic [6:0] funct7;
        reg_sel_t   rs2;
        reg_sel_t   rs1;
        logic [2:0] funct3;
        reg_sel_t   rd;
        opcode_t    opcode;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_type_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branch_type_t;

endpackage

`default_nettype wire

//--- source/datapath_pkg.sv
// payload structs carried by the pipeline latches between stages
`default_nettype none

`include "datapath_consts.svh"

package datapath_pkg;

    // fetch to scoreboard
    typedef struct packed {
        isa_pkg::word_t instr;
        isa_pkg::word_t pc;
    } fetch_t;

    // scoreboard to execute
    // fu_en picks the unit: alu, load/store, branch
    typedef struct packed {
        logic [`FU_CNT-1:0]    fu_en;
        isa_pkg::alu_op_t      alu_op;
        isa_pkg::mem_type_t    mem_type;
        isa_pkg::branch_type_t branch_type;
        isa_pkg::word_t        rdat1;
        isa_pkg::word_t        rdat2;
        isa_pkg::word_t        imm;
        isa_pkg::word_t        pc;
        isa_pkg::reg_sel_t     rd;
        logic                  halt;
    } issue_t;

    // execute to write-back, done means a register write
    typedef struct packed {
        logic              done;
        isa_pkg::reg_sel_t rd;
        isa_pkg::word_t    wdat;
    } execute_t;

endpackage

`default_nettype wire

//--- source/pipe_latch.sv
// stage register holding one payload of any type with valid, stall and flush
`timescale 1ns/1ps
`default_nettype none

module pipe_latch #(
    parameter type payload_t = logic
) (
    input  logic     CLK,
    input  logic     nrst,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // flush wins over stall so a redirect never keeps wrong-path work
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- source/fetch.sv
// instruction fetch: pc register, imem request and redirect on branch miss
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module fetch (
    input  logic                 CLK,
    input  logic                 nrst,
    input  logic                 ihit,
    input  isa_pkg::word_t       imemload,
    input  logic                 stall,
    input  logic                 branch_miss,
    input  isa_pkg::word_t       branch_target,
    input  logic                 halt,
    output logic                 imemREN,
    output isa_pkg::word_t       imemaddr,
    output logic                 fetch_valid,
    output datapath_pkg::fetch_t fetch_out
);
    import isa_pkg::*;

    word_t pc_q;
    word_t target_q;
    logic  redirect_q;
    logic  req_done;

    assign imemREN  = !halt;
    assign imemaddr = pc_q;
    assign req_done = imemREN && ihit;

    // words returned while a redirect is pending are wrong-path
    assign fetch_valid = req_done && !redirect_q;
    assign fetch_out   = '{instr: imemload, pc: pc_q};

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc_q       <= `PC_RESET;
            redirect_q <= 1'b0;
        end else if (branch_miss && !req_done) begin
            // open request keeps its address until the hit
            redirect_q <= 1'b1;
        end else if (branch_miss) begin
            pc_q       <= branch_target;
            redirect_q <= 1'b0;
        end else if (req_done && redirect_q) begin
            pc_q       <= target_q;
            redirect_q <= 1'b0;
        end else if (req_done && !stall) begin
            pc_q <= pc_q + word_t'(4);
        end
    end

    // target of a deferred redirect
    always_ff @(posedge CLK) begin
        if (branch_miss) begin
            target_q <= branch_target;
        end
    end

endmodule

`default_nettype wire

//--- source/scoreboard.sv
// decode, register file, busy-bit hazard check, issue and register write-back
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module scoreboard (
    input  logic                   CLK,
    input  logic                   nrst,
    input  logic                   fetch_valid,
    input  datapath_pkg::fetch_t   fetch_in,
    input  logic                   ex_busy,
    input  logic                   branch_miss,
    input  datapath_pkg::execute_t wb_in,
    output logic                   sb_stall,
    output logic                   issue_valid,
    output datapath_pkg::issue_t   issue_out
);
    import isa_pkg::*;

    instr_t              instr;
    word_t               w;
    word_t               regs [`REG_CNT];
    logic [`REG_CNT-1:0] busy_q;
    logic [`REG_CNT-1:0] wb_clr;
    logic [`REG_CNT-1:0] busy_eff;
    word_t               rdat1;
    word_t               rdat2;
    logic                use_rs1;
    logic                use_rs2;
    logic                wr_rd;
    logic                hazard;
    logic                issue_fire;
    reg_sel_t            pend_rd;
    logic                pend_wr;

    function automatic alu_op_t alu_decode(input logic [2:0] funct3, input logic alt);
        alu_op_t op;
        case (funct3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b010:  op = ALU_SLT;
            3'b100:  op = ALU_XOR;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign w     = fetch_in.instr;
    assign instr = instr_t'(w);

    // read ports, same-cycle write-back data bypasses the array
    assign rdat1 = (instr.rs1 == '0) ? '0 :
                   (wb_in.done && wb_in.rd == instr.rs1) ? wb_in.wdat : regs[instr.rs1];
    assign rdat2 = (instr.rs2 == '0) ? '0 :
                   (wb_in.done && wb_in.rd == instr.rs2) ? wb_in.wdat : regs[instr.rs2];

    always_comb begin
        issue_out             = '0;
        issue_out.alu_op      = ALU_ADD;
        issue_out.mem_type    = MEM_NONE;
        issue_out.branch_type = BR_NONE;
        issue_out.rdat1       = rdat1;
        issue_out.rdat2       = rdat2;
        issue_out.pc          = fetch_in.pc;
        issue_out.rd          = instr.rd;
        use_rs1               = 1'b0;
        use_rs2               = 1'b0;
        wr_rd                 = 1'b0;
        if (w == `HALT_WORD) begin
            issue_out.halt = 1'b1;
        end else begin
            case (instr.opcode)
                OP_RTYPE: begin
                    issue_out.fu_en[`FU_ALU] = 1'b1;
                    issue_out.alu_op = alu_decode(instr.funct3, instr.funct7[5]);
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                    wr_rd   = 1'b1;
                end
                OP_ITYPE: begin
                    // immediate takes the second operand slot
                    issue_out.fu_en[`FU_ALU] = 1'b1;
                    issue_out.alu_op = alu_decode(instr.funct3, 1'b0);
                    issue_out.imm    = {{(`WORD_W-12){w[31]}}, w[31:20]};
                    issue_out.rdat2  = issue_out.imm;
                    use_rs1 = 1'b1;
                    wr_rd   = 1'b1;
                end
                OP_LOAD: begin
                    issue_out.fu_en[`FU_LSU] = 1'b1;
                    issue_out.mem_type = MEM_LOAD;
                    issue_out.imm      = {{(`WORD_W-12){w[31]}}, w[31:20]};
                    use_rs1 = 1'b1;
                    wr_rd   = 1'b1;
                end
                OP_STORE: begin
                    issue_out.fu_en[`FU_LSU] = 1'b1;
                    issue_out.mem_type = MEM_STORE;
                    issue_out.imm      = {{(`WORD_W-12){w[31]}}, w[31:25], w[11:7]};
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
                OP_BRANCH: begin
                    issue_out.fu_en[`FU_BRU] = 1'b1;
                    issue_out.branch_type = instr.funct3[0] ? BR_NE : BR_EQ;
                    issue_out.imm = {{(`WORD_W-12){w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
                default: ;
            endcase
        end
        // x0 never becomes busy
        if (instr.rd == '0) begin
            wr_rd = 1'b0;
        end
    end

    // busy bits released by this cycle's write-back no longer block
    assign wb_clr   = wb_in.done ? (`REG_CNT'(1) << wb_in.rd) : '0;
    assign busy_eff = busy_q & ~wb_clr;
    assign hazard   = (use_rs1 && busy_eff[instr.rs1]) ||
                      (use_rs2 && busy_eff[instr.rs2]) ||
                      (wr_rd && busy_eff[instr.rd]);

    assign sb_stall    = fetch_valid && hazard;
    assign issue_valid = fetch_valid && !hazard;
    assign issue_fire  = issue_valid && !ex_busy;

    // the one instruction issuing beside a missed branch is flushed,
    // so its busy set is dropped
    assign pend_rd = instr.rd;
    assign pend_wr = issue_fire && wr_rd && !branch_miss;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_eff | (pend_wr ? (`REG_CNT'(1) << pend_rd) : '0);
        end
    end

    always_ff @(posedge CLK) begin
        if (wb_in.done && wb_in.rd != '0) begin
            regs[wb_in.rd] <= wb_in.wdat;
        end
    end

endmodule

`default_nettype wire

//--- source/execute.sv
// execute stage: scalar ALU, load/store unit on the dmem port, branch resolution
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module execute (
    input  logic                   CLK,
    input  logic                   nrst,
    input  logic                   issue_valid,
    input  datapath_pkg::issue_t   issue_in,
    input  logic                   dhit,
    input  isa_pkg::word_t         dmemload,
    output logic                   dmemREN,
    output logic                   dmemWEN,
    output isa_pkg::word_t         dmemaddr,
    output isa_pkg::word_t         dmemstore,
    output logic                   ex_busy,
    output logic                   branch_miss,
    output isa_pkg::word_t         branch_target,
    output logic                   halt,
    output logic                   ex_valid,
    output datapath_pkg::execute_t ex_out
);
    import isa_pkg::*;

    logic  alu_en;
    logic  lsu_en;
    logic  bru_en;
    logic  is_load;
    logic  taken;
    logic  halt_q;
    word_t op_a;
    word_t op_b;
    word_t alu_res;

    assign op_a = issue_in.rdat1;
    assign op_b = issue_in.rdat2;

    // nothing runs once the machine has halted
    assign alu_en = issue_valid && issue_in.fu_en[`FU_ALU] && !halt_q;
    assign lsu_en = issue_valid && issue_in.fu_en[`FU_LSU] && !halt_q;
    assign bru_en = issue_valid && issue_in.fu_en[`FU_BRU] && !halt_q;

    always_comb begin
        case (issue_in.alu_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {{(`WORD_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_res = '0;
        endcase
    end

    // request stays up, and the issue latch frozen, until dhit
    assign is_load   = issue_in.mem_type == MEM_LOAD;
    assign dmemaddr  = op_a + issue_in.imm;
    assign dmemstore = op_b;
    assign dmemREN   = lsu_en && is_load;
    assign dmemWEN   = lsu_en && issue_in.mem_type == MEM_STORE;
    assign ex_busy   = lsu_en && !dhit;

    // predicted not taken, so every taken branch is a miss
    always_comb begin
        case (issue_in.branch_type)
            BR_EQ:   taken = op_a == op_b;
            BR_NE:   taken = op_a != op_b;
            default: taken = 1'b0;
        endcase
    end

    assign branch_miss   = bru_en && taken;
    assign branch_target = issue_in.pc + issue_in.imm;

    assign ex_valid = alu_en || bru_en || (lsu_en && dhit);
    assign ex_out   = '{done: alu_en || (lsu_en && dhit && is_load),
                        rd:   issue_in.rd,
                        wdat: is_load ? dmemload : alu_res};

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            halt_q <= 1'b0;
        end else if (issue_valid && issue_in.halt) begin
            halt_q <= 1'b1;
        end
    end

    assign halt = halt_q;

endmodule

`default_nettype wire

//--- source/sc_datapath.sv
// datapath top: fetch, scoreboard and execute joined by three pipeline latches
`timescale 1ns/1ps
`default_nettype none

module sc_datapath (
    input  logic           CLK,
    input  logic           nrst,
    input  logic           ihit,
    input  isa_pkg::word_t imemload,
    output logic           imemREN,
    output isa_pkg::word_t imemaddr,
    input  logic           dhit,
    input  isa_pkg::word_t dmemload,
    output logic           dmemREN,
    output logic           dmemWEN,
    output isa_pkg::word_t dmemaddr,
    output isa_pkg::word_t dmemstore,
    output logic           halt
);
    import isa_pkg::*;
    import datapath_pkg::*;

    fetch_t   fetch_d;
    fetch_t   fetch_q;
    issue_t   issue_d;
    issue_t   issue_q;
    execute_t ex_d;
    execute_t wb_q;
    execute_t wb_in;
    logic     fetch_d_valid;
    logic     fetch_q_valid;
    logic     issue_d_valid;
    logic     issue_q_valid;
    logic     ex_d_valid;
    logic     wb_q_valid;
    logic     sb_stall;
    logic     ex_busy;
    logic     fetch_stall;
    logic     branch_miss;
    word_t    branch_target;

    assign fetch_stall = sb_stall || ex_busy;

    // write-back slot only counts while the latch is valid
    assign wb_in = '{done: wb_q_valid && wb_q.done, rd: wb_q.rd, wdat: wb_q.wdat};

    fetch u_fetch (
        .CLK, .nrst, .ihit, .imemload, .stall(fetch_stall),
        .branch_miss, .branch_target, .halt, .imemREN, .imemaddr,
        .fetch_valid(fetch_d_valid), .fetch_out(fetch_d)
    );

    pipe_latch #(.payload_t(fetch_t)) fetch_latch (
        .CLK, .nrst, .stall(fetch_stall), .flush(branch_miss),
        .in_valid(fetch_d_valid), .in_data(fetch_d),
        .out_valid(fetch_q_valid), .out_data(fetch_q)
    );

    scoreboard u_scoreboard (
        .CLK, .nrst, .fetch_valid(fetch_q_valid), .fetch_in(fetch_q),
        .ex_busy, .branch_miss, .wb_in, .sb_stall,
        .issue_valid(issue_d_valid), .issue_out(issue_d)
    );

    pipe_latch #(.payload_t(issue_t)) issue_latch (
        .CLK, .nrst, .stall(ex_busy), .flush(branch_miss),
        .in_valid(issue_d_valid), .in_data(issue_d),
        .out_valid(issue_q_valid), .out_data(issue_q)
    );

    execute u_execute (
        .CLK, .nrst, .issue_valid(issue_q_valid), .issue_in(issue_q),
        .dhit, .dmemload, .dmemREN, .dmemWEN, .dmemaddr, .dmemstore,
        .ex_busy, .branch_miss, .branch_target, .halt,
        .ex_valid(ex_d_valid), .ex_out(ex_d)
    );

    pipe_latch #(.payload_t(execute_t)) wb_latch (
        .CLK, .nrst, .stall(1'b0), .flush(1'b0),
        .in_valid(ex_d_valid), .in_data(ex_d),
        .out_valid(wb_q_valid), .out_data(wb_q)
    );

endmodule

`default_nettype wire

//--- test/dp_checker.sv
// watches stores, halt and the reset state of the datapath and compares them with expected values
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module dp_checker #(
    parameter int MAX_REC    = 64,
    parameter int HALT_LIMIT = 5000
) (
    input  logic           CLK,
    input  logic           nrst,
    input  logic           imemREN,
    input  isa_pkg::word_t imemaddr,
    input  logic           dmemREN,
    input  logic           dmemWEN,
    input  logic           dhit,
    input  isa_pkg::word_t dmemaddr,
    input  isa_pkg::word_t dmemstore,
    input  logic           halt,
    output logic           finished,
    output int             fail_cnt
);
    import isa_pkg::*;

    word_t exp_addr [MAX_REC];
    word_t exp_data [MAX_REC];
    int    exp_cnt  = 0;
    int    seen_cnt = 0;
    int    pass_cnt = 0;

    task automatic add_expected(input word_t addr, input word_t data);
        if (exp_cnt < MAX_REC) begin
            exp_addr[exp_cnt] = addr;
            exp_data[exp_cnt] = data;
            exp_cnt = exp_cnt + 1;
        end else begin
            $display("too many expected stores, record for 0x%08h dropped", addr);
        end
    endtask

    // fetch starts at the reset pc with the data port and halt idle
    task automatic check_reset_state();
        logic ok;
        ok = 1'b1;
        if (imemREN !== 1'b1) begin
            $display("Mismatch imemREN: expected 0x1, got 0x%0h", imemREN);
            ok = 1'b0;
        end
        if (imemaddr !== `PC_RESET) begin
            $display("Mismatch imemaddr: expected 0x%08h, got 0x%08h", `PC_RESET, imemaddr);
            ok = 1'b0;
        end
        if (dmemREN !== 1'b0) begin
            $display("Mismatch dmemREN: expected 0x0, got 0x%0h", dmemREN);
            ok = 1'b0;
        end
        if (dmemWEN !== 1'b0) begin
            $display("Mismatch dmemWEN: expected 0x0, got 0x%0h", dmemWEN);
            ok = 1'b0;
        end
        if (halt !== 1'b0) begin
            $display("Mismatch halt: expected 0x0, got 0x%0h", halt);
            ok = 1'b0;
        end
        if (ok) begin
            pass_cnt = pass_cnt + 1;
            $display("reset state ok");
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("reset state wrong");
        end
    endtask

    task automatic check_store();
        logic ok;
        ok = 1'b1;
        if (halt) begin
            $display("a store to 0x%08h appeared after halt rose", dmemaddr);
            ok = 1'b0;
        end
        if (seen_cnt >= exp_cnt) begin
            $display("extra store beyond the %0d expected: addr 0x%08h data 0x%08h",
                     exp_cnt, dmemaddr, dmemstore);
            ok = 1'b0;
        end else begin
            if (dmemaddr !== exp_addr[seen_cnt]) begin
                $display("Mismatch dmemaddr: expected 0x%08h, got 0x%08h",
                         exp_addr[seen_cnt], dmemaddr);
                ok = 1'b0;
            end
            if (dmemstore !== exp_data[seen_cnt]) begin
                $display("Mismatch dmemstore: expected 0x%08h, got 0x%08h",
                         exp_data[seen_cnt], dmemstore);
                ok = 1'b0;
            end
        end
        if (ok) begin
            pass_cnt = pass_cnt + 1;
            $display("store %0d: addr 0x%08h data 0x%08h ok", seen_cnt, dmemaddr, dmemstore);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("store %0d: wrong", seen_cnt);
        end
        seen_cnt = seen_cnt + 1;
    endtask

    // a store ends in the cycle where dhit meets dmemWEN
    always @(negedge CLK) begin
        if (nrst && dmemWEN && dhit) begin
            check_store();
        end
    end

    initial begin : watch_halt
        int cycles;
        finished = 1'b0;
        fail_cnt = 0;
        cycles   = 0;
        // first falling edge out of reset
        while (nrst !== 1'b1 && cycles < HALT_LIMIT) begin
            @(negedge CLK);
            cycles = cycles + 1;
        end
        check_reset_state();
        while (halt !== 1'b1 && cycles < HALT_LIMIT) begin
            @(negedge CLK);
            cycles = cycles + 1;
        end
        if (halt !== 1'b1) begin
            $display("halt never rose within %0d cycles", HALT_LIMIT);
            fail_cnt = fail_cnt + 1;
        end else begin
            // any store in this quiet window is late
            repeat (20) @(negedge CLK);
        end
        if (seen_cnt < exp_cnt) begin
            $display("missing stores: only %0d of %0d expected stores appeared",
                     seen_cnt, exp_cnt);
            fail_cnt = fail_cnt + 1;
        end
        $display("store checks done: %0d passed, %0d failed", pass_cnt, fail_cnt);
        finished = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/tb_sc_datapath.sv
// simulation top with clock, reset, program loading and a random-latency memory for the datapath
`timescale 1ns/1ps
`default_nettype none

module tb_sc_datapath;
    import isa_pkg::*;

    localparam int MEM_IDX_W  = 10;
    localparam int MEM_WORDS  = 1 << MEM_IDX_W;
    localparam int FILE_WORDS = 256;
    localparam int RUN_LIMIT  = 6000;

    logic   CLK;
    logic   nrst;
    logic   ihit;
    word_t  imemload;
    logic   imemREN;
    word_t  imemaddr;
    logic   dhit;
    word_t  dmemload;
    logic   dmemREN;
    logic   dmemWEN;
    word_t  dmemaddr;
    word_t  dmemstore;
    logic   halt;
    logic   finished;
    int     fail_cnt;
    logic   load_ok;

    word_t  mem [MEM_WORDS];
    word_t  file_words [FILE_WORDS];
    integer seed;
    int     i_wait;
    int     d_wait;
    logic   i_armed;
    logic   d_armed;

    sc_datapath uut (
        .CLK, .nrst, .ihit, .imemload, .imemREN, .imemaddr,
        .dhit, .dmemload, .dmemREN, .dmemWEN, .dmemaddr, .dmemstore, .halt
    );

    dp_checker chk (
        .CLK, .nrst, .imemREN, .imemaddr, .dmemREN, .dmemWEN, .dhit,
        .dmemaddr, .dmemstore, .halt, .finished, .fail_cnt
    );

    always #5 CLK = ~CLK;

    // the file holds a word count, the image words, a record count and address/data pairs
    task automatic load_program();
        int k;
        int n;
        int m;
        for (k = 0; k < MEM_WORDS; k++) begin
            mem[k] = 32'hbad0_0000 | (word_t'(k) << 2);
        end
        $readmemh("test/program_input.hex", file_words);
        n = int'(file_words[0]);
        load_ok = !$isunknown(file_words[0]) && n > 0 && n < FILE_WORDS - 1;
        if (!load_ok) begin
            $display("could not read a program image from test/program_input.hex");
        end else begin
            for (k = 0; k < n; k++) begin
                mem[k] = file_words[1 + k];
            end
            m = int'(file_words[1 + n]);
            for (k = 0; k < m; k++) begin
                chk.add_expected(file_words[2 + n + 2 * k], file_words[3 + n + 2 * k]);
            end
            $display("loaded %0d image words and %0d expected stores", n, m);
        end
    endtask

    // each port has one open request answered after 0 to 3 idle cycles
    // hit and data stay up for a single cycle
    always @(posedge CLK) begin
        if (!nrst) begin
            ihit    <= 1'b0;
            dhit    <= 1'b0;
            i_armed = 1'b0;
            d_armed = 1'b0;
        end else begin
            if (ihit) begin
                ihit    <= 1'b0;
                i_armed = 1'b0;
            end else if (imemREN) begin
                if (!i_armed) begin
                    i_wait  = $unsigned($random(seed)) % 4;
                    i_armed = 1'b1;
                end
                if (i_wait == 0) begin
                    ihit     <= 1'b1;
                    imemload <= mem[imemaddr[2 +: MEM_IDX_W]];
                end else begin
                    i_wait = i_wait - 1;
                end
            end
            if (dhit) begin
                // store data lands as the hit cycle ends
                if (dmemWEN) begin
                    mem[dmemaddr[2 +: MEM_IDX_W]] = dmemstore;
                end
                dhit    <= 1'b0;
                d_armed = 1'b0;
            end else if (dmemREN || dmemWEN) begin
                if (!d_armed) begin
                    d_wait  = $unsigned($random(seed)) % 4;
                    d_armed = 1'b1;
                end
                if (d_wait == 0) begin
                    dhit     <= 1'b1;
                    dmemload <= mem[dmemaddr[2 +: MEM_IDX_W]];
                end else begin
                    d_wait = d_wait - 1;
                end
            end
        end
    end

    initial begin : main
        int cycles;
        CLK      = 1'b0;
        nrst     = 1'b0;
        ihit     = 1'b0;
        imemload = '0;
        dhit     = 1'b0;
        dmemload = '0;
        seed     = 32'h62c1_cbf2;
        i_wait   = 0;
        d_wait   = 0;
        i_armed  = 1'b0;
        d_armed  = 1'b0;
        load_program();
        repeat (3) @(posedge CLK);
        nrst <= 1'b1;
        cycles = 0;
        while (finished !== 1'b1 && cycles < RUN_LIMIT) begin
            @(posedge CLK);
            cycles = cycles + 1;
        end
        if (finished !== 1'b1) begin
            $display("store checks did not finish within %0d cycles", RUN_LIMIT);
            $display("Test failed");
        end else if (load_ok && fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/program_input.hex
// word count, then image words from address 0 (one per line),
// then record count, then expected stores as: address data
0000001c
00700093 // 00 addi x1, x0, 7
ffd00113 // 04 addi x2, x0, -3
002081b3 // 08 add x3, x1, x2
20302023 // 0c sw x3, 0x200(x0)
40208233 // 10 sub x4, x1, x2
20402223 // 14 sw x4, 0x204(x0)
0020f2b3 // 18 and x5, x1, x2
20502423 // 1c sw x5, 0x208(x0)
0020e333 // 20 or x6, x1, x2
20602623 // 24 sw x6, 0x20c(x0)
0020c3b3 // 28 xor x7, x1, x2
20702823 // 2c sw x7, 0x210(x0)
00112433 // 30 slt x8, x2, x1
20802a23 // 34 sw x8, 0x214(x0)
00508493 // 38 addi x9, x1, 5
009484b3 // 3c add x9, x9, x9
401484b3 // 40 sub x9, x9, x1
20902c23 // 44 sw x9, 0x218(x0)
06c02503 // 48 lw x10, 0x6c(x0)
01050593 // 4c addi x11, x10, 16
20b02e23 // 50 sw x11, 0x21c(x0)
00108463 // 54 beq x1, x1, +8
22102023 // 58 sw x1, 0x220(x0), skipped
00109463 // 5c bne x1, x1, +8
22402223 // 60 sw x4, 0x224(x0)
ffffffff // 64 halt
22102423 // 68 sw x1, 0x228(x0), never runs
12345670 // 6c data word for the load
00000009
00000200 00000004
00000204 0000000a
00000208 00000005
0000020c ffffffff
00000210 fffffffa
00000214 00000001
00000218 00000011
0000021c 12345680
00000224 0000000a

//--- src.f
+incdir+source
source/isa_pkg.sv
source/datapath_pkg.sv
source/pipe_latch.sv
source/fetch.sv
source/scoreboard.sv
source/execute.sv
source/sc_datapath.sv
test/dp_checker.sv
test/tb_sc_datapath.sv

//--- Bender.yml
package:
  name: sc_datapath

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/isa_pkg.sv
      - source/datapath_pkg.sv
      - source/pipe_latch.sv
      - source/fetch.sv
      - source/scoreboard.sv
      - source/execute.sv
      - source/sc_datapath.sv

  - target: test
    include_dirs:
      - source
    files:
      - test/dp_checker.sv
      - test/tb_sc_datapath.sv
